// ==== Bender.yml ====
package:
  name: cic_decim

sources:
  - cic_pkg.sv
  - cic_integ.sv
  - cic_diff.sv
  - cic_scale.sv
  - cic_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_cic.sv

// ==== build.f ====
+incdir+.
cic_pkg.sv
cic_integ.sv
cic_diff.sv
cic_scale.sv
cic_top.sv
tb_cic.sv

// ==== cic_diff.sv ====
`timescale 1ns/1ns
`default_nettype none

module cic_diff (
	input wire clk,
	input wire rst_n,
	// serial snapshot words from the integrators
	input wire [cic_pkg::acc_w-1:0] d_in,
	input wire g_in,
	// second-order difference, same channel order
	output logic signed [cic_pkg::acc_w-1:0] d_out,
	output logic g_out
);
	import cic_pkg::*;

	// previous and second-previous snapshot of every channel
	logic [acc_w-1:0] hist1 [n_chan];
	logic [acc_w-1:0] hist2 [n_chan];

	// outputs of the two delay lines, aligned with the channel on d_in
	logic [acc_w-1:0] prev1;
	logic [acc_w-1:0] prev2;

	// n_chan words back on the stream is the same channel one burst ago
	assign prev1 = hist1[n_chan-1];
	// second line is fed by the first one
	assign prev2 = hist2[n_chan-1];

	// both lines step only when a word arrives
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < n_chan; i++) begin
				hist1[i] <= '0;
				hist2[i] <= '0;
			end
		end else if (g_in) begin
			hist1[0] <= d_in;
			hist2[0] <= prev1;
			for (int i = 1; i < n_chan; i++) begin
				hist1[i] <= hist1[i-1];
				hist2[i] <= hist2[i-1];
			end
		end
	end

	// x - 2*x1 + x2, modulo 2**acc_w
	// integrator wraparound cancels out here
	always_ff @(posedge clk) begin
		if (g_in)
			d_out <= d_in - (prev1 << 1) + prev2;
	end

	// one cycle of latency for the strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			g_out <= 1'b0;
		else
			g_out <= g_in;
	end

endmodule

`default_nettype wire

// ==== cic_integ.sv ====
`timescale 1ns/1ns
`default_nettype none

module cic_integ (
	input wire clk,
	input wire rst_n,
	// one pulse per ADC sample
	input wire sample_en,
	// channel 0 sits in the lowest in_w bits
	input wire [cic_pkg::n_chan*cic_pkg::in_w-1:0] adc_data,
	// sample_en pulses per decimation period
	input wire [cic_pkg::period_w-1:0] period,
	output logic [cic_pkg::acc_w-1:0] sr_data,
	output logic sr_valid
);
	import cic_pkg::*;

	// double integrator state, one pair per channel
	logic [acc_w-1:0] integ1 [n_chan];
	logic [acc_w-1:0] integ2 [n_chan];
	logic [acc_w-1:0] integ1_next [n_chan];
	logic [acc_w-1:0] integ2_next [n_chan];

	// period bookkeeping
	logic [period_w-1:0] samp_cnt;
	logic [period_w-1:0] per_q;
	logic [period_w-1:0] cur_per;
	logic period_end;

	// snapshot of all second integrators, drained one word per cycle
	logic [n_chan*acc_w-1:0] snap;
	logic [chan_w-1:0] burst_cnt;

	always_comb begin
		for (int i = 0; i < n_chan; i++) begin
			// sign-extend the sample into the accumulator width
			integ1_next[i] = integ1[i] + {{(acc_w-in_w){adc_data[i*in_w+in_w-1]}},
				adc_data[i*in_w +: in_w]};
			// second stage takes the freshly updated first stage
			integ2_next[i] = integ2[i] + integ1_next[i];
		end
	end

	// first sample of a period uses the live period input
	assign cur_per = (samp_cnt == '0) ? period : per_q;
	assign period_end = sample_en && (samp_cnt == cur_per - 1'b1);

	// accumulators wrap freely, the differences downstream undo it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < n_chan; i++) begin
				integ1[i] <= '0;
				integ2[i] <= '0;
			end
		end else if (sample_en) begin
			for (int i = 0; i < n_chan; i++) begin
				integ1[i] <= integ1_next[i];
				integ2[i] <= integ2_next[i];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_cnt <= '0;
			per_q <= '0;
		end else if (sample_en) begin
			// hold the period for the whole decimation interval
			if (samp_cnt == '0)
				per_q <= period;
			if (period_end)
				samp_cnt <= '0;
			else
				samp_cnt <= samp_cnt + 1'b1;
		end
	end

	// burst control, a new period end restarts the burst
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sr_valid <= 1'b0;
			burst_cnt <= '0;
		end else if (period_end) begin
			sr_valid <= 1'b1;
			burst_cnt <= '0;
		end else if (sr_valid) begin
			burst_cnt <= burst_cnt + 1'b1;
			if (burst_cnt == chan_w'(n_chan - 1))
				sr_valid <= 1'b0;
		end
	end

	// load includes the sample taken on the completing edge
	always_ff @(posedge clk) begin
		if (period_end) begin
			for (int i = 0; i < n_chan; i++)
				snap[i*acc_w +: acc_w] <= integ2_next[i];
		end else if (sr_valid) begin
			snap <= snap >> acc_w;
		end
	end

	// channel 0 leaves first
	assign sr_data = snap[acc_w-1:0];

endmodule

`default_nettype wire

// ==== cic_pkg.sv ====
`default_nettype none

package cic_pkg;

	// width of one raw ADC sample per channel
	localparam int in_w = 18;

	// channels handled in one pass, also the number of words in a burst
	localparam int n_chan = 8;
	localparam int chan_w = $clog2(n_chan);

	// decimation period control
	localparam int period_w = 8;
	localparam int max_period = 2**period_w - 1;

	// a burst of n_chan words has to drain before the next period ends
	localparam int min_period = n_chan;

	// growth of a second-order CIC is period squared
	localparam int acc_w = in_w + 2*$clog2(max_period + 1);

	// scaled and saturated result
	localparam int out_w = 20;

	// barrel shift amount, 0 to 15
	localparam int shift_w = 4;

endpackage

`default_nettype wire

// ==== cic_scale.sv ====
`timescale 1ns/1ns
`default_nettype none

module cic_scale (
	input wire clk,
	input wire rst_n,
	// differentiated words and their strobe
	input wire [cic_pkg::acc_w-1:0] d_in,
	input wire g_in,
	// compensates for the period squared gain
	input wire [cic_pkg::shift_w-1:0] shift,
	output logic signed [cic_pkg::out_w-1:0] result,
	output logic [cic_pkg::chan_w-1:0] chan,
	output logic ovf,
	output logic strobe
);
	import cic_pkg::*;

	// first stage, shift and keep out_w+1 bits
	logic signed [acc_w-1:0] d_shift;
	logic clip_hi;
	logic signed [out_w:0] d_keep;
	logic sign_keep;
	logic clip_keep;
	logic v_keep;

	// second stage saturate decision
	logic sat;

	// arithmetic shift keeps the sign in the upper bits
	assign d_shift = $signed(d_in) >>> shift;

	// bits from the kept msb upward must be all zeros or all ones
	assign clip_hi = ~((&d_shift[acc_w-1:out_w]) | ~(|d_shift[acc_w-1:out_w]));

	always_ff @(posedge clk) begin
		d_keep <= d_shift[out_w:0];
		// true sign survives even when the kept bits are wrong
		sign_keep <= d_shift[acc_w-1];
		clip_keep <= clip_hi;
	end

	// clipped upstream, or the extra kept bit disagrees with the msb
	assign sat = clip_keep | (d_keep[out_w] ^ d_keep[out_w-1]);

	// pin to the largest value of the right sign
	always_ff @(posedge clk) begin
		if (sat)
			result <= {sign_keep, {(out_w-1){~sign_keep}}};
		else
			result <= d_keep[out_w-1:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v_keep <= 1'b0;
			strobe <= 1'b0;
			ovf <= 1'b0;
			chan <= '0;
		end else begin
			v_keep <= g_in;
			strobe <= v_keep;
			// flag only travels with a valid result
			ovf <= v_keep & sat;
			// index follows the strobe, back to 0 in the gaps
			// wraps mod n_chan across back-to-back bursts
			if (v_keep && strobe)
				chan <= chan + 1'b1;
			else
				chan <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== cic_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cic_top (
	input wire clk,
	input wire rst_n,
	input wire sample_en,
	// all channels side by side, channel 0 lowest
	input wire [cic_pkg::n_chan*cic_pkg::in_w-1:0] adc_data,
	input wire [cic_pkg::period_w-1:0] period,
	input wire [cic_pkg::shift_w-1:0] shift,
	output logic signed [cic_pkg::out_w-1:0] result,
	output logic [cic_pkg::chan_w-1:0] chan,
	output logic ovf,
	output logic strobe
);
	import cic_pkg::*;

	// integrator snapshot stream
	logic [acc_w-1:0] sr_data;
	logic sr_valid;

	// differentiated stream
	logic signed [acc_w-1:0] diff_data;
	logic diff_valid;

	// integrators and period counter
	cic_integ i_integ (
		.clk(clk),
		.rst_n(rst_n),
		.sample_en(sample_en),
		.adc_data(adc_data),
		.period(period),
		.sr_data(sr_data),
		.sr_valid(sr_valid)
	);

	// two cascaded differences across bursts
	cic_diff i_diff (
		.clk(clk),
		.rst_n(rst_n),
		.d_in(sr_data),
		.g_in(sr_valid),
		.d_out(diff_data),
		.g_out(diff_valid)
	);

	// shift, saturate and label
	cic_scale i_scale (
		.clk(clk),
		.rst_n(rst_n),
		.d_in(diff_data),
		.g_in(diff_valid),
		.shift(shift),
		.result(result),
		.chan(chan),
		.ovf(ovf),
		.strobe(strobe)
	);

endmodule

`default_nettype wire

// ==== tb_cic_model.svh ====
// reference model of the decimator, stepped by the testbench from reset
// two integrators and the two previous snapshots per channel
logic [acc_w-1:0] m_int1 [n_chan];
logic [acc_w-1:0] m_int2 [n_chan];
logic [acc_w-1:0] m_hist1 [n_chan];
logic [acc_w-1:0] m_hist2 [n_chan];
int m_cnt;
int m_per;

// closed form x*P*P for constant input, from the third burst of a run
logic closed_on;
int closed_burst;

// 32-bit xorshift, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic void model_reset();
	for (int i = 0; i < n_chan; i++) begin
		m_int1[i] = '0;
		m_int2[i] = '0;
		m_hist1[i] = '0;
		m_hist2[i] = '0;
	end
	m_cnt = 0;
	m_per = 0;
	closed_on = 1'b0;
	closed_burst = 0;
endfunction

// arithmetic right shift, then clamp into the signed out_w range
function automatic logic signed [out_w-1:0] scale_sat(input logic [acc_w-1:0] d,
		input int sh, output logic clip);
	longint v;
	longint hi;
	longint lo;
	v = longint'($signed(d)) >>> sh;
	hi = (longint'(1) <<< (out_w - 1)) - 1;
	lo = -hi - 1;
	clip = (v > hi) || (v < lo);
	if (v > hi)
		v = hi;
	else if (v < lo)
		v = lo;
	return out_w'(v);
endfunction

// one sample of the CIC sum; a completed period queues a full burst
function automatic void model_step(input logic [n_chan*in_w-1:0] x, input int per,
		input int sh);
	logic [acc_w-1:0] s;
	logic [acc_w-1:0] snap;
	logic [acc_w-1:0] d;
	logic signed [out_w-1:0] r;
	logic clip;
	longint cf;
	// period is taken at the first sample of each interval
	if (m_cnt == 0)
		m_per = per;
	m_cnt++;
	for (int i = 0; i < n_chan; i++) begin
		s = acc_w'($signed(x[i*in_w +: in_w]));
		m_int1[i] = m_int1[i] + s;
		m_int2[i] = m_int2[i] + m_int1[i];
	end
	if (m_cnt == m_per) begin
		m_cnt = 0;
		if (closed_on)
			closed_burst++;
		for (int i = 0; i < n_chan; i++) begin
			snap = m_int2[i];
			// second difference across snapshots, wraps mod 2**acc_w
			d = snap - 2 * m_hist1[i] + m_hist2[i];
			m_hist2[i] = m_hist1[i];
			m_hist1[i] = snap;
			r = scale_sat(d, sh, clip);
			if (closed_on && closed_burst >= 3) begin
				cf = longint'($signed(x[i*in_w +: in_w])) * m_per * m_per;
				r = out_w'(cf >>> sh);
				clip = 1'b0;
			end
			exp_res.push_back(r);
			exp_ovf.push_back(clip);
			exp_chan.push_back(i);
		end
	end
endfunction

// ==== tb_cic.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cic;
	import cic_pkg::*;

	// drive cycles of all tests, plus drain allowance per wait
	localparam int run_cycles = 8 + 5*16 + 400 + 6*8 + 41 + 31 + 65;
	localparam int drain_max = 40;
	localparam int n_drains = 7;
	localparam int limit_cycles = 3 + run_cycles + n_drains*(drain_max + 4) + 100;

	logic clk;
	logic rst_n;
	logic sample_en;
	logic [n_chan*in_w-1:0] adc_data;
	logic [period_w-1:0] period;
	logic [shift_w-1:0] shift;
	logic signed [out_w-1:0] result;
	logic [chan_w-1:0] chan;
	logic ovf;
	logic strobe;

	// expected words, queued by the model and consumed by the monitor
	logic signed [out_w-1:0] exp_res [$];
	logic exp_ovf [$];
	int exp_chan [$];
	logic signed [out_w-1:0] er;
	logic eo;
	int ec;

	int err_cnt;
	int check_cnt;
	int strobe_cnt;
	int ovf_cnt;
	int test_cnt;
	logic [31:0] rng;

	`include "tb_cic_model.svh"

	cic_top i_cic_top (
		.clk(clk),
		.rst_n(rst_n),
		.sample_en(sample_en),
		.adc_data(adc_data),
		.period(period),
		.shift(shift),
		.result(result),
		.chan(chan),
		.ovf(ovf),
		.strobe(strobe)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		#(limit_cycles * 100);
		$display("watchdog expired after %0d cycles, run did not finish", limit_cycles);
		$display("** FAIL **");
		$finish;
	end

	// outputs are registered, so mid-cycle they are settled
	always @(negedge clk) begin
		if (strobe === 1'b1) begin
			strobe_cnt++;
			if (ovf)
				ovf_cnt++;
			assert (exp_res.size() != 0) else begin
				$display("strobe at %0t arrived with no result pending", $time);
				err_cnt++;
			end
			if (exp_res.size() != 0) begin
				er = exp_res.pop_front();
				eo = exp_ovf.pop_front();
				ec = exp_chan.pop_front();
				check_cnt++;
				assert (result === er && ovf === eo && chan == ec) else begin
					$display("Mismatch at %0t: chan %0d result %0d ovf %b, expected %0d %0d %b",
						$time, chan, result, ovf, ec, er, eo);
					err_cnt++;
				end
			end
		end
	end

	function automatic logic [n_chan*in_w-1:0] rand_frame();
		logic [n_chan*in_w-1:0] f;
		for (int i = 0; i < n_chan; i++) begin
			rng = xorshift32(rng);
			f[i*in_w +: in_w] = rng[in_w-1:0];
		end
		return f;
	endfunction

	// one cycle of stimulus, 10 ns after the rising edge
	task automatic drive(input logic en, input logic [n_chan*in_w-1:0] x);
		@(posedge clk);
		#10;
		sample_en = en;
		adc_data = x;
		if (en)
			model_step(x, period, shift);
	endtask

	// idle until every queued word has come out, then a few more cycles
	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_res.size() != 0 && n < drain_max) begin
			drive(1'b0, adc_data);
			n++;
		end
		repeat (4)
			drive(1'b0, adc_data);
		assert (exp_res.size() == 0) else begin
			$display("%0d expected strobes never arrived by %0t", exp_res.size(), $time);
			err_cnt++;
			exp_res.delete();
			exp_ovf.delete();
			exp_chan.delete();
		end
	endtask

	task automatic report(input string name, input int err0);
		test_cnt++;
		if (err_cnt == err0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, err_cnt - err0);
	endtask

	// no strobe before the period completes, then one burst of n_chan
	task automatic test_reset_state();
		int err0;
		int s0;
		err0 = err_cnt;
		s0 = strobe_cnt;
		period = 8;
		shift = 0;
		repeat (8)
			drive(1'b1, rand_frame());
		wait_drain();
		assert (strobe_cnt - s0 == n_chan) else begin
			$display("first burst gave %0d strobes, wanted %0d", strobe_cnt - s0, n_chan);
			err_cnt++;
		end
		report("reset_state", err0);
	endtask

	// distinct constant per channel, alternating sign
	task automatic test_constant();
		int err0;
		logic [n_chan*in_w-1:0] frame;
		err0 = err_cnt;
		for (int i = 0; i < n_chan; i++)
			frame[i*in_w +: in_w] = in_w'((i % 2 ? -1 : 1) * (i + 1) * 1000);
		period = 16;
		shift = 4;
		closed_on = 1'b1;
		closed_burst = 0;
		repeat (5*16)
			drive(1'b1, frame);
		wait_drain();
		closed_on = 1'b0;
		report("constant", err0);
	endtask

	// about one cycle in four has no sample
	task automatic test_random_gaps();
		int err0;
		logic en;
		err0 = err_cnt;
		period = 10;
		shift = 7;
		repeat (400) begin
			rng = xorshift32(rng);
			en = rng[0] | rng[1];
			drive(en, rand_frame());
		end
		wait_drain();
		report("random_gaps", err0);
	endtask

	// channels 0 and 1 at full scale, the rest small
	task automatic test_saturation();
		int err0;
		int o0;
		int s0;
		logic [n_chan*in_w-1:0] frame;
		err0 = err_cnt;
		for (int i = 0; i < n_chan; i++)
			frame[i*in_w +: in_w] = in_w'(i * 25);
		frame[0 +: in_w] = in_w'(131071);
		frame[in_w +: in_w] = in_w'(-131072);
		period = 8;
		shift = 0;
		o0 = ovf_cnt;
		s0 = strobe_cnt;
		repeat (6*8)
			drive(1'b1, frame);
		wait_drain();
		assert (ovf_cnt > o0 && strobe_cnt - ovf_cnt > s0 - o0) else begin
			$display("saturation run did not mix clipped and clean results");
			err_cnt++;
		end
		report("saturation", err0);
	endtask

	// segments stop mid-period, so each new period starts one interval late
	task automatic test_period_change();
		int err0;
		int pers[3] = '{12, 9, 20};
		int shs[3] = '{5, 3, 7};
		int lens[3] = '{41, 31, 65};
		err0 = err_cnt;
		for (int k = 0; k < 3; k++) begin
			period = pers[k];
			shift = shs[k];
			repeat (lens[k])
				drive(1'b1, rand_frame());
			wait_drain();
		end
		report("period_change", err0);
	endtask

	initial begin
		rng = 32'd88941;
		err_cnt = 0;
		check_cnt = 0;
		strobe_cnt = 0;
		ovf_cnt = 0;
		test_cnt = 0;
		rst_n = 1'b0;
		sample_en = 1'b0;
		adc_data = '0;
		period = 8;
		shift = 0;
		model_reset();
		repeat (3)
			@(posedge clk);
		#10;
		rst_n = 1'b1;
		test_reset_state();
		test_constant();
		test_random_gaps();
		test_saturation();
		test_period_change();
		$display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
